// ==== source/mips_params.svh ====
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// word width of the datapath and both memory ports
`define DATA_WIDTH 32

// five bits select one of 32 registers
`define REG_ADDR_WIDTH 5

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== source/mips_pkg.sv ====
package mips_pkg;

	// alu function select, set by the decoder
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4,
		ALU_SLL = 3'd5
	} aluOp;

	// data memory access kind carried down the pipe
	typedef enum logic [3:0] {
		MEM_NONE = 4'd0,
		// loads
		MEM_LB   = 4'd1,
		MEM_LBU  = 4'd2,
		MEM_LH   = 4'd3,
		MEM_LHU  = 4'd4,
		MEM_LW   = 4'd5,
		// stores
		MEM_SB   = 4'd6,
		MEM_SH   = 4'd7,
		MEM_SW   = 4'd8
	} memKind;

endpackage

// ==== source/controlDecoder.sv ====
module controlDecoder import mips_pkg::*; (
	input  logic [5:0] opcode,
	input  logic [5:0] funct,
	output logic       regWrite,
	output logic       regDst,
	output logic       aluSrc,
	output logic       zeroExt,
	output logic       memToReg,
	output logic       branch,
	output logic       jump,
	output aluOp       aluControl,
	output memKind     access
);

	always_comb begin
		// anything not listed below behaves as a nop
		regWrite   = 1'b0;
		regDst     = 1'b0;
		aluSrc     = 1'b0;
		zeroExt    = 1'b0;
		memToReg   = 1'b0;
		branch     = 1'b0;
		jump       = 1'b0;
		aluControl = ALU_ADD;
		access     = MEM_NONE;
		case (opcode)
			6'b000000: begin
				regDst   = 1'b1;
				regWrite = 1'b1;
				case (funct)
					6'b100001: aluControl = ALU_ADD;
					6'b100011: aluControl = ALU_SUB;
					6'b100100: aluControl = ALU_AND;
					6'b100101: aluControl = ALU_OR;
					6'b101010: aluControl = ALU_SLT;
					6'b000000: aluControl = ALU_SLL;
					default:   regWrite = 1'b0;
				endcase
			end
			// addiu
			6'b001001: begin
				regWrite = 1'b1;
				aluSrc   = 1'b1;
			end
			// ori takes the zero-extended immediate
			6'b001101: begin
				regWrite   = 1'b1;
				aluSrc     = 1'b1;
				zeroExt    = 1'b1;
				aluControl = ALU_OR;
			end
			6'b000100: begin
				branch     = 1'b1;
				aluControl = ALU_SUB;
			end
			6'b000010: jump = 1'b1;
			// loads, address is base plus offset
			6'b100000, 6'b100100, 6'b100001, 6'b100101, 6'b100011: begin
				regWrite = 1'b1;
				aluSrc   = 1'b1;
				memToReg = 1'b1;
				case (opcode)
					6'b100000: access = MEM_LB;
					6'b100100: access = MEM_LBU;
					6'b100001: access = MEM_LH;
					6'b100101: access = MEM_LHU;
					default:   access = MEM_LW;
				endcase
			end
			6'b101000: begin
				aluSrc = 1'b1;
				access = MEM_SB;
			end
			6'b101001: begin
				aluSrc = 1'b1;
				access = MEM_SH;
			end
			6'b101011: begin
				aluSrc = 1'b1;
				access = MEM_SW;
			end
			default: ;
		endcase
	end

endmodule

// ==== source/regFile.sv ====
`include "mips_params.svh"

module regFile (
	input  logic                       clk,
	input  logic                       writeEnable,
	input  logic [`REG_ADDR_WIDTH-1:0] writeAddr,
	input  logic [`DATA_WIDTH-1:0]     writeData,
	input  logic [`REG_ADDR_WIDTH-1:0] readAddrA,
	input  logic [`REG_ADDR_WIDTH-1:0] readAddrB,
	output logic [`DATA_WIDTH-1:0]     readDataA,
	output logic [`DATA_WIDTH-1:0]     readDataB
);

	logic [`DATA_WIDTH-1:0] regs [2**`REG_ADDR_WIDTH];

	// falling edge write, decode sees it in the same cycle
	always_ff @(negedge clk) begin
		if (writeEnable && writeAddr != '0)
			regs[writeAddr] <= writeData;
	end

	// $0 is hardwired
	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// ==== source/alu.sv ====
`include "mips_params.svh"

module alu import mips_pkg::*; (
	input  logic [`DATA_WIDTH-1:0] a,
	input  logic [`DATA_WIDTH-1:0] b,
	input  logic [4:0]             shamt,
	input  aluOp                   op,
	output logic [`DATA_WIDTH-1:0] result
);

	logic [`DATA_WIDTH-1:0] diff;

	assign diff = a - b;

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = diff;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			// signed compare
			ALU_SLT: result = {{(`DATA_WIDTH-1){1'b0}}, $signed(a) < $signed(b)};
			// sll shifts rt, rs is ignored
			ALU_SLL: result = b << shamt;
			default: result = diff;
		endcase
	end

endmodule

// ==== source/hazardUnit.sv ====
`include "mips_params.svh"

module hazardUnit (
	input  logic [`REG_ADDR_WIDTH-1:0] rsD,
	input  logic [`REG_ADDR_WIDTH-1:0] rtD,
	input  logic [`REG_ADDR_WIDTH-1:0] rsE,
	input  logic [`REG_ADDR_WIDTH-1:0] rtE,
	input  logic                       branchD,
	input  logic [`REG_ADDR_WIDTH-1:0] writeRegE,
	input  logic [`REG_ADDR_WIDTH-1:0] writeRegM,
	input  logic [`REG_ADDR_WIDTH-1:0] writeRegW,
	input  logic                       regWriteE,
	input  logic                       regWriteM,
	input  logic                       regWriteW,
	input  logic                       memToRegE,
	input  logic                       memToRegM,
	output logic                       forwardAD,
	output logic                       forwardBD,
	output logic [1:0]                 forwardAE,
	output logic [1:0]                 forwardBE,
	output logic                       stallF,
	output logic                       stallD,
	output logic                       flushE
);

	logic loadUseStall;
	logic branchStall;

	// memory stage wins over writeback
	always_comb begin
		forwardAE = 2'b00;
		forwardBE = 2'b00;
		if (rsE != '0 && rsE == writeRegM && regWriteM)
			forwardAE = 2'b10;
		else if (rsE != '0 && rsE == writeRegW && regWriteW)
			forwardAE = 2'b01;
		if (rtE != '0 && rtE == writeRegM && regWriteM)
			forwardBE = 2'b10;
		else if (rtE != '0 && rtE == writeRegW && regWriteW)
			forwardBE = 2'b01;
	end

	// branch compare only needs the memory-stage alu result
	assign forwardAD = (rsD != '0) && (rsD == writeRegM) && regWriteM;
	assign forwardBD = (rtD != '0) && (rtD == writeRegM) && regWriteM;

	assign loadUseStall = memToRegE && (rtE == rsD || rtE == rtD);

	// a load in memory holds the branch until writeback
	assign branchStall = branchD &&
		((regWriteE && (writeRegE == rsD || writeRegE == rtD)) ||
		 (memToRegM && (writeRegM == rsD || writeRegM == rtD)));

	assign stallF = loadUseStall | branchStall;
	assign stallD = loadUseStall | branchStall;
	assign flushE = loadUseStall | branchStall;

endmodule

// ==== source/datapath.sv ====
`include "mips_params.svh"

module datapath import mips_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	output logic [`DATA_WIDTH-1:0] instrAddr,
	input  logic [`DATA_WIDTH-1:0] instr,
	output memKind                 memKindE,
	output logic [`DATA_WIDTH-1:0] memAddrE,
	output logic [`DATA_WIDTH-1:0] storeValueE,
	output memKind                 memKindM,
	output logic [1:0]             byteOffsetM,
	input  logic [`DATA_WIDTH-1:0] loadValueM
);

	localparam int W = `DATA_WIDTH;
	localparam int R = `REG_ADDR_WIDTH;

	logic [W-1:0] pcF, pcPlus4F, pcNextF;
	logic [W-1:0] instrD, pcPlus4D, rfDataAD, rfDataBD, srcAD, srcBD;
	logic [W-1:0] immExtD, branchTargetD, jumpTargetD;
	logic [R-1:0] rsD, rtD, rdD;
	logic [4:0]   shamtD;
	logic         regWriteD, regDstD, aluSrcD, zeroExtD, memToRegD, branchD, jumpD;
	logic         equalD, pcSrcD;
	aluOp         aluControlD;
	memKind       accessD;
	logic [W-1:0] rfDataAE, rfDataBE, immExtE, srcAE, srcBE, aluBE, aluOutE;
	logic [R-1:0] rsE, rtE, rdE, writeRegE;
	logic [4:0]   shamtE;
	logic         regWriteE, regDstE, aluSrcE, memToRegE;
	aluOp         aluControlE;
	logic [W-1:0] aluOutM, aluOutW, readDataW, resultW;
	logic [R-1:0] writeRegM, writeRegW;
	logic         regWriteM, memToRegM, regWriteW, memToRegW;
	logic         forwardAD, forwardBD, stallF, stallD, flushE;
	logic [1:0]   forwardAE, forwardBE;

	// fetch, reset and stall folded into the next PC
	assign pcPlus4F = pcF + 32'd4;
	always_comb begin
		if (reset)
			pcNextF = `RESET_PC;
		else if (stallF)
			pcNextF = pcF;
		else if (jumpD)
			pcNextF = jumpTargetD;
		else if (pcSrcD)
			pcNextF = branchTargetD;
		else
			pcNextF = pcPlus4F;
	end
	always_ff @(posedge clk)
		pcF <= pcNextF;
	assign instrAddr = pcNextF;

	always_ff @(posedge clk) begin
		if (reset) begin
			instrD   <= '0;
			pcPlus4D <= '0;
		end else if (!stallD) begin
			instrD   <= instr;
			pcPlus4D <= pcPlus4F;
		end
	end

	// decode
	assign rsD    = instrD[25:21];
	assign rtD    = instrD[20:16];
	assign rdD    = instrD[15:11];
	assign shamtD = instrD[10:6];

	controlDecoder decoder (
		.opcode(instrD[31:26]), .funct(instrD[5:0]),
		.regWrite(regWriteD), .regDst(regDstD), .aluSrc(aluSrcD), .zeroExt(zeroExtD),
		.memToReg(memToRegD), .branch(branchD), .jump(jumpD),
		.aluControl(aluControlD), .access(accessD)
	);

	regFile rf (
		.clk(clk), .writeEnable(regWriteW), .writeAddr(writeRegW), .writeData(resultW),
		.readAddrA(rsD), .readAddrB(rtD), .readDataA(rfDataAD), .readDataB(rfDataBD)
	);

	assign immExtD = zeroExtD ? {16'b0, instrD[15:0]} : {{16{instrD[15]}}, instrD[15:0]};
	assign branchTargetD = pcPlus4D + {immExtD[W-3:0], 2'b00};
	assign jumpTargetD   = {pcPlus4D[31:28], instrD[25:0], 2'b00};

	// branch resolves here
	assign srcAD  = forwardAD ? aluOutM : rfDataAD;
	assign srcBD  = forwardBD ? aluOutM : rfDataBD;
	assign equalD = (srcAD == srcBD);
	assign pcSrcD = branchD & equalD;

	always_ff @(posedge clk) begin
		if (reset || flushE) begin
			regWriteE   <= 1'b0;
			regDstE     <= 1'b0;
			aluSrcE     <= 1'b0;
			memToRegE   <= 1'b0;
			aluControlE <= ALU_ADD;
			memKindE    <= MEM_NONE;
		end else begin
			regWriteE   <= regWriteD;
			regDstE     <= regDstD;
			aluSrcE     <= aluSrcD;
			memToRegE   <= memToRegD;
			aluControlE <= aluControlD;
			memKindE    <= accessD;
		end
	end

	always_ff @(posedge clk) begin
		rfDataAE <= rfDataAD;
		rfDataBE <= rfDataBD;
		immExtE  <= immExtD;
		rsE      <= rsD;
		rtE      <= rtD;
		rdE      <= rdD;
		shamtE   <= shamtD;
	end

	// execute
	always_comb begin
		case (forwardAE)
			2'b10:   srcAE = aluOutM;
			2'b01:   srcAE = resultW;
			default: srcAE = rfDataAE;
		endcase
		case (forwardBE)
			2'b10:   srcBE = aluOutM;
			2'b01:   srcBE = resultW;
			default: srcBE = rfDataBE;
		endcase
	end
	assign aluBE     = aluSrcE ? immExtE : srcBE;
	assign writeRegE = regDstE ? rdE : rtE;

	alu alu (.a(srcAE), .b(aluBE), .shamt(shamtE), .op(aluControlE), .result(aluOutE));

	assign memAddrE    = aluOutE;
	assign storeValueE = srcBE;

	always_ff @(posedge clk) begin
		if (reset) begin
			regWriteM <= 1'b0;
			memToRegM <= 1'b0;
			memKindM  <= MEM_NONE;
			regWriteW <= 1'b0;
			memToRegW <= 1'b0;
		end else begin
			regWriteM <= regWriteE;
			memToRegM <= memToRegE;
			memKindM  <= memKindE;
			regWriteW <= regWriteM;
			memToRegW <= memToRegM;
		end
	end

	always_ff @(posedge clk) begin
		aluOutM   <= aluOutE;
		writeRegM <= writeRegE;
		aluOutW   <= aluOutM;
		readDataW <= loadValueM;
		writeRegW <= writeRegM;
	end

	// memory and writeback
	assign byteOffsetM = aluOutM[1:0];
	assign resultW     = memToRegW ? readDataW : aluOutW;

	hazardUnit hazard (
		.rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE), .branchD(branchD),
		.writeRegE(writeRegE), .writeRegM(writeRegM), .writeRegW(writeRegW),
		.regWriteE(regWriteE), .regWriteM(regWriteM), .regWriteW(regWriteW),
		.memToRegE(memToRegE), .memToRegM(memToRegM),
		.forwardAD(forwardAD), .forwardBD(forwardBD),
		.forwardAE(forwardAE), .forwardBE(forwardBE),
		.stallF(stallF), .stallD(stallD), .flushE(flushE)
	);

endmodule

// ==== source/loadStoreUnit.sv ====
`include "mips_params.svh"

module loadStoreUnit import mips_pkg::*; (
	input  memKind                 kindE,
	input  logic [`DATA_WIDTH-1:0] addrE,
	input  logic [`DATA_WIDTH-1:0] storeValueE,
	output logic [`DATA_WIDTH-1:0] dataAddr,
	output logic                   dataRead,
	output logic                   dataWrite,
	output logic [3:0]             dataByteEnable,
	output logic [`DATA_WIDTH-1:0] dataWriteData,
	input  memKind                 kindM,
	input  logic [1:0]             byteOffsetM,
	input  logic [`DATA_WIDTH-1:0] dataReadData,
	output logic [`DATA_WIDTH-1:0] loadValueM
);

	logic [7:0]  byteM;
	logic [15:0] halfM;

	assign dataAddr  = {addrE[`DATA_WIDTH-1:2], 2'b00};
	assign dataRead  = kindE inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
	assign dataWrite = kindE inside {MEM_SB, MEM_SH, MEM_SW};

	// store lanes replicated, enables pick the target bytes
	always_comb begin
		dataWriteData  = storeValueE;
		dataByteEnable = 4'b0000;
		case (kindE)
			MEM_SB: begin
				dataWriteData  = {4{storeValueE[7:0]}};
				dataByteEnable = 4'b0001 << addrE[1:0];
			end
			MEM_SH: begin
				dataWriteData  = {2{storeValueE[15:0]}};
				dataByteEnable = addrE[1] ? 4'b1100 : 4'b0011;
			end
			MEM_SW:  dataByteEnable = 4'b1111;
			default: dataByteEnable = 4'b0000;
		endcase
	end

	// little-endian lane select for loads
	assign byteM = dataReadData[8*byteOffsetM +: 8];
	assign halfM = byteOffsetM[1] ? dataReadData[31:16] : dataReadData[15:0];

	always_comb begin
		case (kindM)
			MEM_LB:  loadValueM = {{(`DATA_WIDTH-8){byteM[7]}}, byteM};
			MEM_LBU: loadValueM = {{(`DATA_WIDTH-8){1'b0}}, byteM};
			MEM_LH:  loadValueM = {{(`DATA_WIDTH-16){halfM[15]}}, halfM};
			MEM_LHU: loadValueM = {{(`DATA_WIDTH-16){1'b0}}, halfM};
			default: loadValueM = dataReadData;
		endcase
	end

endmodule

// ==== source/mipsCore.sv ====
`include "mips_params.svh"

module mipsCore import mips_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	output logic [`DATA_WIDTH-1:0] instrAddr,
	input  logic [`DATA_WIDTH-1:0] instr,
	output logic [`DATA_WIDTH-1:0] dataAddr,
	output logic                   dataRead,
	output logic                   dataWrite,
	output logic [3:0]             dataByteEnable,
	output logic [`DATA_WIDTH-1:0] dataWriteData,
	input  logic [`DATA_WIDTH-1:0] dataReadData
);

	memKind                 memKindE, memKindM;
	logic [`DATA_WIDTH-1:0] memAddrE, storeValueE, loadValueM;
	logic [1:0]             byteOffsetM;

	datapath dp (
		.clk(clk), .reset(reset), .instrAddr(instrAddr), .instr(instr),
		.memKindE(memKindE), .memAddrE(memAddrE), .storeValueE(storeValueE),
		.memKindM(memKindM), .byteOffsetM(byteOffsetM), .loadValueM(loadValueM)
	);

	// memory stage sees the read data one cycle after execute
	loadStoreUnit lsu (
		.kindE(memKindE), .addrE(memAddrE), .storeValueE(storeValueE),
		.dataAddr(dataAddr), .dataRead(dataRead), .dataWrite(dataWrite),
		.dataByteEnable(dataByteEnable), .dataWriteData(dataWriteData),
		.kindM(memKindM), .byteOffsetM(byteOffsetM), .dataReadData(dataReadData),
		.loadValueM(loadValueM)
	);

endmodule

// ==== bench/mips_assertions.sv ====
module mipsAssertions (
	input logic       clk,
	input logic       reset,
	input logic       dataRead,
	input logic       dataWrite,
	input logic [3:0] dataByteEnable,
	input logic       stallD,
	input logic       flushE
);

	// pipeline state is unknown until the first reset edge
	bit resetSeen;

	always @(posedge clk) begin
		if (reset)
			resetSeen <= 1'b1;
	end

	readWriteExclusive: assert property (@(posedge clk) disable iff (reset || !resetSeen)
		!(dataRead && dataWrite))
		else $error("data read and data write are high together");

	enableOnlyOnWrite: assert property (@(posedge clk) disable iff (reset || !resetSeen)
		!dataWrite |-> dataByteEnable == 4'b0000)
		else $error("byte enables set without a data write");

	enableLegalPattern: assert property (@(posedge clk) disable iff (reset || !resetSeen)
		dataWrite |-> dataByteEnable inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
			4'b0011, 4'b1100, 4'b1111})
		else $error("illegal byte enable pattern on a data write");

	flushNeedsStall: assert property (@(posedge clk) disable iff (reset || !resetSeen)
		flushE |-> stallD)
		else $error("execute flushed without a decode stall");

	noWriteInReset: assert property (@(posedge clk) (reset && resetSeen) |-> !dataWrite)
		else $error("data write during reset");

endmodule

// ==== bench/mips_tb.sv ====
`include "mips_params.svh"

module mipsTb import mips_pkg::*; ();

	localparam int MEM_WORDS = 256;
	localparam int MAX_CASES = 16;
	localparam int MAX_ITEMS = 256;

	logic                   clk;
	logic                   reset;
	logic [`DATA_WIDTH-1:0] instrAddr, instr;
	logic [`DATA_WIDTH-1:0] dataAddr, dataWriteData, dataReadData;
	logic                   dataRead, dataWrite;
	logic [3:0]             dataByteEnable;

	logic [`DATA_WIDTH-1:0] rom [MEM_WORDS];
	logic [`DATA_WIDTH-1:0] ram [MEM_WORDS];
	logic [`DATA_WIDTH-1:0] fillBase;

	// parsed case file
	reg [8*32-1:0]          caseNames [MAX_CASES];
	int                     progStart [MAX_CASES];
	int                     progCount [MAX_CASES];
	int                     storeStart [MAX_CASES];
	int                     storeCount [MAX_CASES];
	logic [`DATA_WIDTH-1:0] progWords [MAX_ITEMS];
	logic [`DATA_WIDTH-1:0] storeAddr [MAX_ITEMS];
	logic [3:0]             storeBe [MAX_ITEMS];
	logic [`DATA_WIDTH-1:0] storeData [MAX_ITEMS];
	int                     numCases, numWords, numStores;

	reg [8*32-1:0]          caseName;
	logic [`DATA_WIDTH-1:0] expAddrQ [$];
	logic [3:0]             expBeQ [$];
	logic [`DATA_WIDTH-1:0] expDataQ [$];
	int                     cycleCount, cycleLimit;

	mipsCore UUT (
		.clk(clk), .reset(reset), .instrAddr(instrAddr), .instr(instr),
		.dataAddr(dataAddr), .dataRead(dataRead), .dataWrite(dataWrite),
		.dataByteEnable(dataByteEnable), .dataWriteData(dataWriteData),
		.dataReadData(dataReadData)
	);

	bind mipsCore mipsAssertions assertChk (
		.clk(clk), .reset(reset), .dataRead(dataRead), .dataWrite(dataWrite),
		.dataByteEnable(dataByteEnable), .stallD(dp.stallD), .flushE(dp.flushE)
	);

	always #5 clk = ~clk;

	task automatic stopFailed();
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	function automatic memKind kindOfEnable(input logic [3:0] be);
		if (be == 4'b1111)
			return MEM_SW;
		if (be == 4'b0011 || be == 4'b1100)
			return MEM_SH;
		return MEM_SB;
	endfunction

	task automatic checkStore(input memKind kind,
			input logic [`DATA_WIDTH-1:0] expAddr, input logic [3:0] expBe,
			input logic [`DATA_WIDTH-1:0] expData, input logic [`DATA_WIDTH-1:0] gotAddr,
			input logic [3:0] gotBe, input logic [`DATA_WIDTH-1:0] gotData);
		if (gotAddr !== expAddr || gotBe !== expBe || gotData !== expData) begin
			$display("Error: case %0s, %s expected addr %h be %b data %h, actual addr %h be %b data %h",
				caseName, kind.name(), expAddr, expBe, expData, gotAddr, gotBe, gotData);
			stopFailed();
		end
	endtask

	// instruction ROM, one cycle read latency
	always @(posedge clk)
		instr <= rom[instrAddr[9:2]];

	// data RAM with byte writes, store checker on the write port
	always @(posedge clk) begin
		// read data only valid after a requested read
		if (dataRead)
			dataReadData <= ram[dataAddr[9:2]];
		else
			dataReadData <= 'x;
		if (!reset && dataWrite) begin
			if (dataByteEnable[0])
				ram[dataAddr[9:2]][7:0] <= dataWriteData[7:0];
			if (dataByteEnable[1])
				ram[dataAddr[9:2]][15:8] <= dataWriteData[15:8];
			if (dataByteEnable[2])
				ram[dataAddr[9:2]][23:16] <= dataWriteData[23:16];
			if (dataByteEnable[3])
				ram[dataAddr[9:2]][31:24] <= dataWriteData[31:24];
			if (expAddrQ.size() == 0) begin
				$display("Unexpected extra store to address %h in case %0s", dataAddr, caseName);
				stopFailed();
			end else begin
				checkStore(kindOfEnable(expBeQ[0]), expAddrQ[0], expBeQ[0], expDataQ[0],
					dataAddr, dataByteEnable, dataWriteData);
				void'(expAddrQ.pop_front());
				void'(expBeQ.pop_front());
				void'(expDataQ.pop_front());
			end
		end
	end

	// run limit covers every case
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
			if (expAddrQ.size() != 0)
				$display("Timeout: case %0s is still missing %0d expected stores",
					caseName, expAddrQ.size());
			else
				$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			stopFailed();
		end
	end

	task automatic readCases();
		int fd;
		int dummy;
		reg [8*32-1:0]  tok;
		reg [8*256-1:0] line;
		bit inStores;
		fd = $fopen("bench/mips_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the case file bench/mips_cases.txt");
			stopFailed();
		end
		inStores = 0;
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok == "#") begin
				dummy = $fgets(line, fd);
			end else if (tok == "fill") begin
				dummy = $fscanf(fd, "%h", fillBase);
			end else if (tok == "case") begin
				dummy = $fscanf(fd, "%s", caseNames[numCases]);
				progStart[numCases]  = numWords;
				storeStart[numCases] = numStores;
				inStores = 0;
				numCases++;
			end else if (tok == "stores") begin
				inStores = 1;
			end else if (tok == "end") begin
				inStores = 0;
			end else if (inStores) begin
				dummy = $sscanf(tok, "%h", storeAddr[numStores]);
				dummy = $fscanf(fd, "%h %h", storeBe[numStores], storeData[numStores]);
				storeCount[numCases-1]++;
				numStores++;
			end else begin
				dummy = $sscanf(tok, "%h", progWords[numWords]);
				progCount[numCases-1]++;
				numWords++;
			end
		end
		$fclose(fd);
	endtask

	task automatic runCase(input int c);
		int i;
		@(posedge clk);
		reset <= 1'b1;
		caseName = caseNames[c];
		for (i = 0; i < MEM_WORDS; i++) begin
			rom[i] = '0;
			ram[i] = fillBase + i * 32'h0101_0101;
		end
		for (i = 0; i < progCount[c]; i++)
			rom[i] = progWords[progStart[c] + i];
		for (i = 0; i < storeCount[c]; i++) begin
			expAddrQ.push_back(storeAddr[storeStart[c] + i]);
			expBeQ.push_back(storeBe[storeStart[c] + i]);
			expDataQ.push_back(storeData[storeStart[c] + i]);
		end
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		while (expAddrQ.size() != 0)
			@(negedge clk);
		// trailing cycles catch stores that should not happen
		repeat (8) @(posedge clk);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instr = '0;
		dataReadData = '0;
		cycleCount = 0;
		cycleLimit = 0;
		readCases();
		cycleLimit = 8 * numWords + 20 * numCases;
		for (int c = 0; c < numCases; c++)
			runCase(c);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+source
source/mips_pkg.sv
source/controlDecoder.sv
source/regFile.sv
source/alu.sv
source/hazardUnit.sv
source/datapath.sv
source/loadStoreUnit.sv
source/mipsCore.sv
bench/mips_assertions.sv
bench/mips_tb.sv

// ==== bench/mips_cases.txt ====
# fill: data RAM word n starts as fill + n * 01010101
# case NAME, program words in hex, then stores as word address, byte enable, write data
fill 80F07F01
case aluOps
24010005 2402FFFD 00221821 00222023 3425F0F0 00A23024 00223825 0041402A 00014900
0022502A AC030100 AC040104 AC050108 AC06010C AC070110 AC080114 AC090118 AC0A011C
stores
00000100 f 00000002
00000104 f 00000008
00000108 f 0000F0F5
0000010C f 0000F0F5
00000110 f FFFFFFFD
00000114 f 00000001
00000118 f 00000050
0000011C f 00000000
end
case forwarding
24010007 00211021 00411821 00622023 AC040120 AC030124 24850001 AC050128
stores
00000120 f 00000007
00000124 f 00000015
00000128 f 00000008
end
case loadUse
8C010000 00211021 AC020130 8C030004 8C040004 10640002 AC030134 AC000138 AC04013C
stores
00000130 f 01E0FE02
00000134 f 81F18002
0000013C f 81F18002
end
case subword
80010005 90020005 84030006 94040006 84050004 80060004 AC010140 AC020144 AC030148
AC04014C AC050150 AC060154 34075678 A0070160 A0070161 A0070162 A0070163 A4070164
A4070166
stores
00000140 f FFFFFF80
00000144 f 00000080
00000148 f FFFF81F1
0000014C f 000081F1
00000150 f FFFF8002
00000154 f 00000002
00000160 1 78787878
00000160 2 78787878
00000160 4 78787878
00000160 8 78787878
00000164 3 56785678
00000164 c 56785678
end
case branches
24010001 24020002 10220003 AC010170 AC020174 10210002 AC010178 AC00017C 0800000B
AC020180 AC000184 AC010188
stores
00000170 f 00000001
00000174 f 00000002
00000178 f 00000001
00000180 f 00000002
00000188 f 00000001
end
